// File: design/complexFir_cfg.svh
/*
 * Complex FIR configuration.
 * Tap count and the widths of samples, coefficients and results.
 */
`ifndef COMPLEX_FIR_CFG_SVH
`define COMPLEX_FIR_CFG_SVH

// Number of complex taps in the filter.
`define FIR_TAPS 12
`define SAMPLE_WIDTH 8
`define COEFF_WIDTH 8
// Wide enough to address every tap.
`define TAP_INDEX_WIDTH 4
// A 16-bit product, 4 bits of growth over 12 taps, one bit for the complex combination.
`define RESULT_WIDTH 21

`endif

// File: design/firSamplePkg.sv
/*
 * Sample domain types of the complex FIR.
 * Signed vectors for samples, coefficients, products, sums and results.
 */
`include "complexFir_cfg.svh"

package firSamplePkg;

	// One real or imaginary component of an input sample.
	typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;
	// One real or imaginary component of a coefficient.
	typedef logic signed [`COEFF_WIDTH-1:0] coeffT;
	// One real product of a sample component and a coefficient component.
	typedef logic signed [`SAMPLE_WIDTH+`COEFF_WIDTH-1:0] productT;
	// A sum of real products over all taps, one bit narrower than a result.
	typedef logic signed [`RESULT_WIDTH-2:0] sumT;
	// One component of the complex filter output.
	typedef logic signed [`RESULT_WIDTH-1:0] resultT;
	// Address of one coefficient in the bank.
	typedef logic [`TAP_INDEX_WIDTH-1:0] tapIndexT;

endpackage

// File: design/firControlPkg.sv
/*
 * Control types of the complex FIR.
 */

package firControlPkg;

	// Controller states.
	// Idle accepts coefficient writes, Run accepts samples,
	// and Flush clears the sample history for one cycle.
	typedef enum logic [1:0] {
		Idle,
		Run,
		Flush
	} firStateT;

endpackage

// File: design/coeffBank.sv
/*
 * Coefficient register bank.
 * Holds one complex coefficient per tap and presents all of them in parallel.
 * Host writes land one tap at a time and only while the filter is unlocked.
 */
`timescale 1ns/1ps
`include "complexFir_cfg.svh"

module coeffBank
	import firSamplePkg::*;
(
	input  logic     clock,
	input  logic     arstN,
	// High while the filter is running or flushing.
	input  logic     lock,
	input  logic     write,
	input  tapIndexT addr,
	input  coeffT    wrRe,
	input  coeffT    wrIm,
	output coeffT    coefRe [0:`FIR_TAPS-1],
	output coeffT    coefIm [0:`FIR_TAPS-1]
);

	// A write is honored only when the bank is unlocked.
	logic writeAllowed;
	// Addresses past the last tap do not map to a register.
	logic addrInRange;

	assign writeAllowed = write && !lock;
	assign addrInRange = addr < tapIndexT'(`FIR_TAPS);

	// The bank comes out of reset with every coefficient at zero,
	// so the filter output is silent until the host loads a table.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				coefRe[i] <= '0;
				coefIm[i] <= '0;
			end
		end else if (writeAllowed && addrInRange) begin
			// Real and imaginary parts of one tap change together.
			coefRe[addr] <= wrRe;
			coefIm[addr] <= wrIm;
		end
	end

	// The table is read combinationally by the MAC pipeline.
	// A stop does not touch the bank, so the
	// coefficients survive from one run to the next.

	// Writes attempted during a run are lost for good.
	// The host has to repeat them once the filter is idle again.

endmodule

// File: design/firController.sv
/*
 * FIR run controller.
 * Moves between Idle, Run and Flush, and decides which offered samples
 * are accepted and when the sample history is cleared.
 */
`timescale 1ns/1ps

module firController
	import firControlPkg::*;
(
	input  logic clock,
	input  logic arstN,
	// Level request to run the filter.
	input  logic start,
	// Single-cycle request to end the run.
	input  logic stop,
	input  logic sampleValid,
	output logic busy,
	output logic sampleAccept,
	output logic flush
);

	firStateT state;
	firStateT stateNext;

	// Next state logic.
	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				if (start) begin
					stateNext = Run;
				end
			end
			Run: begin
				// A sample offered with stop is still taken in this cycle.
				if (stop) begin
					stateNext = Flush;
				end
			end
			// The flush takes exactly one cycle.
			Flush: stateNext = Idle;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
		end else begin
			state <= stateNext;
		end
	end

	// The outputs decode the registered state directly.
	// Busy therefore rises at the edge that enters Run and falls
	// at the edge that leaves Flush.
	assign busy = (state != Idle);

	// This is the only place that looks at sampleValid.
	// Downstream blocks see just the accept strobe.
	assign sampleAccept = sampleValid && (state == Run);

	assign flush = (state == Flush);

endmodule

// File: design/sampleDelayLine.sv
/*
 * Complex sample delay line.
 * Tap 0 holds the newest accepted sample and tap 11 the oldest one.
 */
`timescale 1ns/1ps
`include "complexFir_cfg.svh"

module sampleDelayLine
	import firSamplePkg::*;
(
	input  logic   clock,
	input  logic   arstN,
	input  logic   shift,
	input  logic   flush,
	input  sampleT inRe,
	input  sampleT inIm,
	output sampleT tapRe [0:`FIR_TAPS-1],
	output sampleT tapIm [0:`FIR_TAPS-1]
);

	// Flush wins over shift.
	// The controller never raises both in the same cycle, but the
	// history must end up empty whichever way that goes.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				tapRe[i] <= '0;
				tapIm[i] <= '0;
			end
		end else if (flush) begin
			for (int i = 0; i < `FIR_TAPS; i++) begin
				tapRe[i] <= '0;
				tapIm[i] <= '0;
			end
		end else if (shift) begin
			// Every tap moves one place older and the oldest sample drops out.
			for (int i = `FIR_TAPS - 1; i > 0; i--) begin
				tapRe[i] <= tapRe[i-1];
				tapIm[i] <= tapIm[i-1];
			end
			tapRe[0] <= inRe;
			tapIm[0] <= inIm;
		end
	end

	// The taps are visible one edge after the accept.
	// The MAC pipeline samples them at the following edge.

endmodule

// File: design/complexMacPipe.sv
/*
 * Complex multiply-accumulate pipeline.
 * Stage one forms the four real convolution sums over all taps.
 * Stage two combines them into the complex result.
 */
`timescale 1ns/1ps
`include "complexFir_cfg.svh"

module complexMacPipe
	import firSamplePkg::*;
(
	input  logic   clock,
	input  logic   arstN,
	input  logic   accept,
	input  sampleT tapRe [0:`FIR_TAPS-1],
	input  sampleT tapIm [0:`FIR_TAPS-1],
	input  coeffT  coefRe [0:`FIR_TAPS-1],
	input  coeffT  coefIm [0:`FIR_TAPS-1],
	output logic   resultValid,
	output resultT resultRe,
	output resultT resultIm
);

	// Accept flag after the shift edge, when the taps hold the new sample.
	logic acceptD;
	// Valid flag that travels with the stage one sums.
	logic sumValid;

	// Combinational sums over the current taps.
	// The two letters name the sample part and then the coefficient part.
	sumT accRR;
	sumT accII;
	sumT accRI;
	sumT accIR;

	// Stage one registers.
	sumT sumRR;
	sumT sumII;
	sumT sumRI;
	sumT sumIR;

	// Tap i pairs with coefficient i, so coefficient i weights
	// the sample that was accepted i samples earlier.
	always_comb begin
		productT prodRR;
		productT prodII;
		productT prodRI;
		productT prodIR;
		accRR = '0;
		accII = '0;
		accRI = '0;
		accIR = '0;
		for (int i = 0; i < `FIR_TAPS; i++) begin
			prodRR = tapRe[i] * coefRe[i];
			prodII = tapIm[i] * coefIm[i];
			prodRI = tapRe[i] * coefIm[i];
			prodIR = tapIm[i] * coefRe[i];
			// Twelve products of 16 bits fit in 20 bits without wrapping.
			accRR = accRR + sumT'(prodRR);
			accII = accII + sumT'(prodII);
			accRI = accRI + sumT'(prodRI);
			accIR = accIR + sumT'(prodIR);
		end
	end

	// The valid flags follow the data through both stages, so a result
	// appears exactly two edges after its accept edge.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			acceptD <= 1'b0;
			sumValid <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			acceptD <= accept;
			sumValid <= acceptD;
			resultValid <= sumValid;
		end
	end

	// Stage one.
	always_ff @(posedge clock) begin
		sumRR <= accRR;
		sumII <= accII;
		sumRI <= accRI;
		sumIR <= accIR;
	end

	// Stage two applies (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	// The extra bit of resultT keeps the combination exact.
	always_ff @(posedge clock) begin
		resultRe <= resultT'(sumRR) - resultT'(sumII);
		resultIm <= resultT'(sumRI) + resultT'(sumIR);
	end

endmodule

// File: design/complexFirTop.sv
/*
 * Complex FIR filter top level.
 * Connects the coefficient bank, the run controller, the sample
 * delay line and the MAC pipeline.
 */
`timescale 1ns/1ps
`include "complexFir_cfg.svh"

module complexFirTop
	import firSamplePkg::*;
(
	input  logic     clock,
	input  logic     arstN,
	input  logic     start,
	input  logic     stop,
	input  logic     sampleValid,
	input  sampleT   sampleRe,
	input  sampleT   sampleIm,
	input  logic     coeffWrite,
	input  tapIndexT coeffAddr,
	input  coeffT    coeffRe,
	input  coeffT    coeffIm,
	output logic     resultValid,
	output resultT   resultRe,
	output resultT   resultIm,
	output logic     busy
);

	logic sampleAccept;
	logic flush;
	sampleT tapRe [0:`FIR_TAPS-1];
	sampleT tapIm [0:`FIR_TAPS-1];
	coeffT coefRe [0:`FIR_TAPS-1];
	coeffT coefIm [0:`FIR_TAPS-1];

	// Busy doubles as the bank lock, so the table cannot change under a run.
	coeffBank bank0 (
		.clock  (clock),
		.arstN  (arstN),
		.lock   (busy),
		.write  (coeffWrite),
		.addr   (coeffAddr),
		.wrRe   (coeffRe),
		.wrIm   (coeffIm),
		.coefRe (coefRe),
		.coefIm (coefIm)
	);

	firController controller0 (
		.clock        (clock),
		.arstN        (arstN),
		.start        (start),
		.stop         (stop),
		.sampleValid  (sampleValid),
		.busy         (busy),
		.sampleAccept (sampleAccept),
		.flush        (flush)
	);

	sampleDelayLine delay0 (
		.clock (clock),
		.arstN (arstN),
		.shift (sampleAccept),
		.flush (flush),
		.inRe  (sampleRe),
		.inIm  (sampleIm),
		.tapRe (tapRe),
		.tapIm (tapIm)
	);

	// The pipeline delays the accept itself to line up with the shifted taps.
	complexMacPipe mac0 (
		.clock       (clock),
		.arstN       (arstN),
		.accept      (sampleAccept),
		.tapRe       (tapRe),
		.tapIm       (tapIm),
		.coefRe      (coefRe),
		.coefIm      (coefIm),
		.resultValid (resultValid),
		.resultRe    (resultRe),
		.resultIm    (resultIm)
	);

endmodule

// File: bench/complexFir_properties.sv
/*
 * Timing properties of the complex FIR filter.
 * Bound into the top level to watch the pipeline latency and the controller.
 */
`timescale 1ns/1ps

module complexFirProperties
	import firControlPkg::*;
(
	input logic     clock,
	input logic     arstN,
	input logic     sampleAccept,
	input logic     resultValid,
	input logic     flush,
	input logic     busy,
	input firStateT state
);

	// An accept sampled at one edge is seen as resultValid three edges later.
	// That is the cycle after the second pipeline edge.
	acceptLatency: assert property (@(posedge clock) disable iff (!arstN)
		sampleAccept |-> ##3 resultValid)
		else $error("resultValid did not follow an accepted sample after two cycles");

	// Every result must trace back to exactly one accept.
	noSpuriousResult: assert property (@(posedge clock) disable iff (!arstN)
		resultValid |-> $past(sampleAccept, 3))
		else $error("resultValid appeared without an accept two cycles earlier");

	// The flush is a single cycle and always ends in Idle.
	singleFlush: assert property (@(posedge clock) disable iff (!arstN)
		flush |=> (!flush && !busy))
		else $error("flush lasted more than one cycle or busy stayed high after it");

	legalState: assert property (@(posedge clock) disable iff (!arstN)
		state inside {Idle, Run, Flush})
		else $error("controller state holds an illegal encoding");

endmodule

bind complexFirTop complexFirProperties props0 (
	.clock        (clock),
	.arstN        (arstN),
	.sampleAccept (sampleAccept),
	.resultValid  (resultValid),
	.flush        (flush),
	.busy         (busy),
	.state        (controller0.state)
);

// File: bench/complexFirTb.sv
/*
 * Testbench for the complex FIR filter.
 * Models the coefficient bank, the controller and the sample history, and
 * checks every result and its arrival time against a reference convolution.
 */
`timescale 1ns/1ps
`include "complexFir_cfg.svh"

module complexFirTb
	import firSamplePkg::*;
();

	localparam int clockPeriod = 20;
	localparam int resetCycles = 16;
	localparam int tapCount = `FIR_TAPS;
	localparam int burstLength = 40;
	localparam int gappedSamples = 30;
	// All writes and samples, gaps of up to three cycles, and start, stop and drain overhead.
	localparam int stimCycles = 12 * tapCount + burstLength + 4 * gappedSamples + 100;
	localparam int watchdogNs = (resetCycles + stimCycles) * clockPeriod + 1000;
	localparam int idleState = 0;
	localparam int runState = 1;
	localparam int flushState = 2;

	logic clock, arstN, start, stop, sampleValid, coeffWrite;
	logic resultValid, busy;
	sampleT sampleRe, sampleIm;
	tapIndexT coeffAddr;
	coeffT coeffRe, coeffIm;
	resultT resultRe, resultIm;

	int seed = 32'h973e_bd7b;
	// Model of the bank and of the accepted samples, newest at index 0.
	int coefModelRe [tapCount];
	int coefModelIm [tapCount];
	int histRe [tapCount];
	int histIm [tapCount];
	int modelState;
	// Expected results in accept order, with the negedge where each must show up.
	int expRe [$];
	int expIm [$];
	time expAt [$];

	complexFirTop dut0 (.*);

	always #(clockPeriod / 2) clock = ~clock;

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Stopped at the first error.");
	endtask

	// Convolution over the modelled history, with (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	function automatic void referenceResult(output int yRe, output int yIm);
		yRe = 0;
		yIm = 0;
		for (int i = 0; i < tapCount; i++) begin
			yRe += histRe[i] * coefModelRe[i] - histIm[i] * coefModelIm[i];
			yIm += histRe[i] * coefModelIm[i] + histIm[i] * coefModelRe[i];
		end
	endfunction

	// Mostly full scale values, so the sums get close to their limits.
	function automatic int extremeValue();
		int pick;
		pick = $random(seed);
		case (pick & 3)
			0: return -128;
			1: return 127;
			2: return -127;
			default: return (pick >>> 8) % 128;
		endcase
	endfunction

	function automatic int randomByte();
		return int'(sampleT'($random(seed)));
	endfunction

	// The model sees the same pre-edge inputs as the DUT.
	always @(posedge clock) begin
		int yRe;
		int yIm;
		if (!arstN) begin
			modelState = idleState;
			for (int i = 0; i < tapCount; i++) begin
				coefModelRe[i] = 0;
				coefModelIm[i] = 0;
				histRe[i] = 0;
				histIm[i] = 0;
			end
		end else begin
			// Writes count only while idle and only for an existing tap.
			if (coeffWrite && modelState == idleState && int'(coeffAddr) < tapCount) begin
				coefModelRe[coeffAddr] = int'(coeffRe);
				coefModelIm[coeffAddr] = int'(coeffIm);
			end
			if (sampleValid && modelState == runState) begin
				for (int i = tapCount - 1; i > 0; i--) begin
					histRe[i] = histRe[i-1];
					histIm[i] = histIm[i-1];
				end
				histRe[0] = int'(sampleRe);
				histIm[0] = int'(sampleIm);
				referenceResult(yRe, yIm);
				expRe.push_back(yRe);
				expIm.push_back(yIm);
				// Valid in the cycle after the second edge, checked in its middle.
				expAt.push_back($time + 5 * clockPeriod / 2);
			end
			if (modelState == flushState) begin
				for (int i = 0; i < tapCount; i++) begin
					histRe[i] = 0;
					histIm[i] = 0;
				end
			end
			case (modelState)
				idleState: modelState = start ? runState : idleState;
				runState: modelState = stop ? flushState : runState;
				default: modelState = idleState;
			endcase
		end
	end

	// Outputs are compared at the falling edge, where they are stable.
	always @(negedge clock) begin
		// Busy is high in Run and Flush and low only in Idle.
		if (arstN) begin
			assert (busy == (modelState != idleState)) else reportFailure($sformatf(
				"FAILED at time %0t: busy is %0b, expected %0b", $time, busy,
				modelState != idleState));
		end
		if (arstN && resultValid) begin
			assert (expAt.size() != 0)
				else reportFailure("A result appeared with no accepted sample pending.");
			assert ($time == expAt[0]) else reportFailure($sformatf(
				"FAILED at time %0t: result arrived off time, expected at %0t", $time, expAt[0]));
			assert (int'(resultRe) == expRe[0]) else reportFailure($sformatf(
				"FAILED at time %0t: resultRe is %0d, expected %0d", $time, resultRe, expRe[0]));
			assert (int'(resultIm) == expIm[0]) else reportFailure($sformatf(
				"FAILED at time %0t: resultIm is %0d, expected %0d", $time, resultIm, expIm[0]));
			expRe.delete(0);
			expIm.delete(0);
			expAt.delete(0);
		end else if (arstN && expAt.size() != 0) begin
			assert ($time < expAt[0]) else reportFailure($sformatf(
				"FAILED at time %0t: no result, one was expected at %0t", $time, expAt[0]));
		end
	end

	task automatic driveIdle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			sampleValid <= 1'b0;
			coeffWrite <= 1'b0;
			start <= 1'b0;
			stop <= 1'b0;
		end
	endtask

	task automatic writeCoeff(input int addr, input int re, input int im);
		@(posedge clock);
		coeffWrite <= 1'b1;
		coeffAddr <= tapIndexT'(addr);
		coeffRe <= coeffT'(re);
		coeffIm <= coeffT'(im);
	endtask

	task automatic offerSample(input int re, input int im);
		@(posedge clock);
		sampleValid <= 1'b1;
		sampleRe <= sampleT'(re);
		sampleIm <= sampleT'(im);
	endtask

	// Start is held for one cycle, the run then continues on its own.
	task automatic startRun();
		driveIdle(1);
		start <= 1'b1;
		driveIdle(1);
	endtask

	task automatic waitIdle();
		do begin
			@(negedge clock);
		end while (busy);
	endtask

	// A stop pulse, with an optional sample in the same cycle.
	task automatic stopRun(input bit withSample, input int re, input int im);
		if (withSample) begin
			offerSample(re, im);
		end else begin
			driveIdle(1);
		end
		stop <= 1'b1;
		driveIdle(1);
		waitIdle();
	endtask

	task automatic drainResults();
		do begin
			@(posedge clock);
		end while (expAt.size() != 0);
	endtask

	initial begin
		clock = 1'b0;
		arstN = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		sampleValid = 1'b0;
		sampleRe = '0;
		sampleIm = '0;
		coeffWrite = 1'b0;
		coeffAddr = '0;
		coeffRe = '0;
		coeffIm = '0;
		repeat (resetCycles) @(posedge clock);
		arstN <= 1'b1;
		@(negedge clock);
		assert (!busy && !resultValid) else reportFailure($sformatf(
			"FAILED at time %0t: busy or resultValid is high after reset", $time));

		// Samples offered while idle must vanish.
		for (int k = 0; k < 4; k++) begin
			offerSample(100, -50);
		end
		driveIdle(8);

		// A unit impulse reads the table out in tap order, and an impulse of i rotates it.
		for (int k = 0; k < tapCount; k++) begin
			writeCoeff(k, 9 * k - 50, 40 - 7 * k);
		end
		startRun();
		offerSample(1, 0);
		for (int k = 1; k < tapCount; k++) begin
			offerSample(0, 0);
		end
		offerSample(0, 1);
		for (int k = 1; k < tapCount; k++) begin
			offerSample(0, 0);
		end
		stopRun(1'b0, 0, 0);
		drainResults();

		// Random table, then extreme samples in a burst and with gaps.
		for (int k = 0; k < tapCount; k++) begin
			writeCoeff(k, randomByte(), randomByte());
		end
		writeCoeff(13, 55, 55);
		startRun();
		for (int k = 0; k < burstLength; k++) begin
			offerSample(extremeValue(), extremeValue());
		end
		for (int k = 0; k < gappedSamples; k++) begin
			offerSample(extremeValue(), extremeValue());
			driveIdle($random(seed) & 3);
		end
		stopRun(1'b0, 0, 0);
		drainResults();

		// Writes during a run are dropped, the same writes while idle land.
		startRun();
		for (int k = 0; k < tapCount; k += 3) begin
			writeCoeff(k, k - 100, 77 - k);
		end
		driveIdle(1);
		for (int k = 0; k < tapCount; k++) begin
			offerSample(extremeValue(), extremeValue());
		end
		stopRun(1'b0, 0, 0);
		drainResults();
		for (int k = 0; k < tapCount; k += 3) begin
			writeCoeff(k, k - 100, 77 - k);
		end
		startRun();
		for (int k = 0; k < tapCount; k++) begin
			offerSample(extremeValue(), extremeValue());
		end

		// The sample offered with stop still counts, and a restart begins with an empty history.
		stopRun(1'b1, -128, 127);
		drainResults();
		startRun();
		for (int k = 0; k <= tapCount; k++) begin
			offerSample(extremeValue(), extremeValue());
		end
		stopRun(1'b0, 0, 0);
		driveIdle(4);
		assert (expAt.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			reportFailure("Expected results were still pending at the end of the test.");
		end
	end

	initial begin
		#(watchdogNs);
		reportFailure("Timeout: the test did not finish in the expected time.");
	end

endmodule

// File: filelist.f
+incdir+design
design/firSamplePkg.sv
design/firControlPkg.sv
design/coeffBank.sv
design/firController.sv
design/sampleDelayLine.sv
design/complexMacPipe.sv
design/complexFirTop.sv
bench/complexFir_properties.sv
bench/complexFirTb.sv

// File: Makefile
# Verilator build and run of the complex FIR filter testbench.
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= complexFirTb
FILELIST ?= filelist.f
OBJDIR ?= obj_dir
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check its output"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR)
